// File: Makefile
TOP = decodeStage_tb

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f build.f --Mdir obj_dir -o simv

run: compile
	./obj_dir/simv | tee sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: compile run clean

// File: build.f
+incdir+source
source/decode_pkg.sv
source/instDecoder.sv
source/branchUnit.sv
source/issueRegister.sv
source/decodeStage.sv
tests/decodeStage_properties.sv
tests/decodeStage_tb.sv

// File: source/branchUnit.sv
`default_nettype none

`include "decode_defs.svh"

module branchUnit
    import decode_pkg::*;
(
    input  logic             inValid,
    input  logic             flush,
    input  ctrlType_e        decType,
    input  exeCtrl_t         decCtrl,
    input  logic [`XLEN-1:0] decImm,
    input  logic [`XLEN-1:0] rs1Data,
    input  logic [`XLEN-1:0] rs2Data,
    output logic             redirect,
    output logic [`XLEN-1:0] nextPc
);

    logic             taken;
    logic [`XLEN-1:0] seqPc;
    logic [`XLEN-1:0] pcTarget;
    logic [`XLEN-1:0] regTarget;

    assign seqPc     = decCtrl.pc + `XLEN'(`PC_STEP);
    assign pcTarget  = decCtrl.pc + decImm;
    assign regTarget = (rs1Data + decImm) & ~`XLEN'(1);

    // funct3 of the branch sits in the low bits of rd
    always_comb begin
        case (decCtrl.rd[2:0])
            3'b000:  taken = rs1Data == rs2Data;
            3'b001:  taken = rs1Data != rs2Data;
            3'b100:  taken = $signed(rs1Data) < $signed(rs2Data);
            3'b101:  taken = $signed(rs1Data) >= $signed(rs2Data);
            3'b110:  taken = rs1Data < rs2Data;
            3'b111:  taken = rs1Data >= rs2Data;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        case (decType)
            CT_JAL:    nextPc = pcTarget;
            CT_JALR:   nextPc = regTarget;
            CT_BRANCH: nextPc = taken ? pcTarget : seqPc;
            default:   nextPc = seqPc;
        endcase
    end

    // fetch has to restart at nextPc for every resolved control transfer
    assign redirect = inValid && !flush && decCtrl.trap == TRAP_NONE && decType != CT_NOP;

endmodule

`default_nettype wire

// File: source/decodeStage.sv
`default_nettype none

`include "decode_defs.svh"

module decodeStage
    import decode_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             inValid,
    input  fetchBundle_t     inBundle,
    input  logic             conflict,
    input  logic             flush,
    input  logic             ifOk,
    input  logic             exeReady,
    output logic             inReady,
    output logic             redirect,
    output logic [`XLEN-1:0] nextPc,
    output logic             outValid,
    output exeCtrl_t         outCtrl
);

    exeCtrl_t         decCtrl;
    ctrlType_e        decType;
    logic [`XLEN-1:0] decImm;

    instDecoder decoder (
        .inBundle (inBundle),
        .decCtrl  (decCtrl),
        .decType  (decType),
        .decImm   (decImm)
    );

    // resolves in the decode cycle, from the operands fetch read out
    branchUnit branch (
        .inValid  (inValid),
        .flush    (flush),
        .decType  (decType),
        .decCtrl  (decCtrl),
        .decImm   (decImm),
        .rs1Data  (inBundle.rs1Data),
        .rs2Data  (inBundle.rs2Data),
        .redirect (redirect),
        .nextPc   (nextPc)
    );

    issueRegister issue (
        .clk      (clk),
        .rst      (rst),
        .inValid  (inValid),
        .flush    (flush),
        .conflict (conflict),
        .ifOk     (ifOk),
        .exeReady (exeReady),
        .decType  (decType),
        .decCtrl  (decCtrl),
        .inReady  (inReady),
        .outValid (outValid),
        .outCtrl  (outCtrl)
    );

endmodule

`default_nettype wire

// File: source/decode_defs.svh
`ifndef DECODE_DEFS_SVH
`define DECODE_DEFS_SVH

// datapath and pc width
`define XLEN 64

// one uncompressed instruction
`define INST_W 32

`define REG_ADDR_W 5 // x0..x31

// sequential fetch advances by one instruction word
`define PC_STEP 4

`endif

// File: source/decode_pkg.sv
`default_nettype none

`include "decode_defs.svh"

package decode_pkg;

    // major opcodes the stage understands, everything else traps as illegal
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_IMM    = 7'b0010011,
        OP_AUIPC  = 7'b0010111,
        OP_IMM32  = 7'b0011011,
        OP_STORE  = 7'b0100011,
        OP_REG    = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_REG32  = 7'b0111011,
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [4:0] {
        ALU_NOP,
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLT,
        ALU_SLTU,
        ALU_ADDW,
        ALU_SUBW,
        ALU_SLLW,
        ALU_SRLW,
        ALU_SRAW
    } aluOp_e;

    // operand pair fed to the ALU
    typedef enum logic [2:0] {
        SRC_NOP,
        SRC_REG_REG,
        SRC_REG_IMM,
        SRC_PC_IMM
    } srcSel_e;

    typedef enum logic [3:0] {
        MEM_NOP,
        MEM_LB,
        MEM_LH,
        MEM_LW,
        MEM_LD,
        MEM_LBU,
        MEM_LHU,
        MEM_LWU,
        MEM_SB,
        MEM_SH,
        MEM_SW,
        MEM_SD
    } memOp_e;

    typedef enum logic [2:0] {
        WB_NOP,
        WB_EXE,
        WB_MEM,
        WB_SNPC, // link address pc + 4
        WB_IMM
    } wbSel_e;

    typedef enum logic [1:0] {
        CT_NOP,
        CT_JAL,
        CT_JALR,
        CT_BRANCH
    } ctrlType_e;

    // fetch codes arrive with the instruction, ILLEGAL is raised here
    typedef enum logic [3:0] {
        TRAP_NONE           = 4'd0,
        TRAP_FETCH_MISALIGN = 4'd1,
        TRAP_FETCH_FAULT    = 4'd2,
        TRAP_ILLEGAL        = 4'd3
    } trap_e;

    typedef struct packed {
        logic [`INST_W-1:0] instruction;
        logic [`XLEN-1:0]   pc;
        logic [`XLEN-1:0]   rs1Data;
        logic [`XLEN-1:0]   rs2Data;
        trap_e              trap;
    } fetchBundle_t;

    typedef struct packed {
        logic [`REG_ADDR_W-1:0] rd;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`XLEN-1:0]       imm;
        logic [`XLEN-1:0]       pc;
        aluOp_e                 aluOp;
        srcSel_e                src;
        memOp_e                 memOp;
        wbSel_e                 wb;
        trap_e                  trap;
    } exeCtrl_t;

endpackage

`default_nettype wire

// File: source/instDecoder.sv
`default_nettype none

`include "decode_defs.svh"

module instDecoder
    import decode_pkg::*;
(
    input  fetchBundle_t     inBundle,
    output exeCtrl_t         decCtrl,
    output ctrlType_e        decType,
    output logic [`XLEN-1:0] decImm
);

    logic [`INST_W-1:0] inst;
    opcode_e            opcode;
    logic [2:0]         funct3;
    logic [5:0]         funct6;
    logic [6:0]         funct7;
    logic [`XLEN-1:0]   immI;
    logic [`XLEN-1:0]   immS;
    logic [`XLEN-1:0]   immB;
    logic [`XLEN-1:0]   immU;
    logic [`XLEN-1:0]   immJ;
    logic               illegal;

    assign inst   = inBundle.instruction;
    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct6 = inst[31:26];
    assign funct7 = inst[31:25];

    assign immI = {{(`XLEN-12){inst[31]}}, inst[31:20]};
    assign immS = {{(`XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
    assign immB = {{(`XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign immU = {{(`XLEN-32){inst[31]}}, inst[31:12], 12'b0};
    assign immJ = {{(`XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        decCtrl     = '0;
        decCtrl.rd  = inst[11:7];
        decCtrl.rs1 = inst[19:15];
        decCtrl.rs2 = inst[24:20];
        decCtrl.pc  = inBundle.pc;
        decImm      = '0;
        decType     = CT_NOP;
        illegal     = 1'b0;

        case (opcode)
            OP_REG: begin
                decCtrl.src = SRC_REG_REG;
                decCtrl.wb  = WB_EXE;
                case ({funct7, funct3})
                    10'b0000000_000: decCtrl.aluOp = ALU_ADD;
                    10'b0100000_000: decCtrl.aluOp = ALU_SUB;
                    10'b0000000_001: decCtrl.aluOp = ALU_SLL;
                    10'b0000000_010: decCtrl.aluOp = ALU_SLT;
                    10'b0000000_011: decCtrl.aluOp = ALU_SLTU;
                    10'b0000000_100: decCtrl.aluOp = ALU_XOR;
                    10'b0000000_101: decCtrl.aluOp = ALU_SRL;
                    10'b0100000_101: decCtrl.aluOp = ALU_SRA;
                    10'b0000000_110: decCtrl.aluOp = ALU_OR;
                    10'b0000000_111: decCtrl.aluOp = ALU_AND;
                    default:         illegal = 1'b1; // M extension lands here too
                endcase
            end
            OP_REG32: begin
                decCtrl.src = SRC_REG_REG;
                decCtrl.wb  = WB_EXE;
                case ({funct7, funct3})
                    10'b0000000_000: decCtrl.aluOp = ALU_ADDW;
                    10'b0100000_000: decCtrl.aluOp = ALU_SUBW;
                    10'b0000000_001: decCtrl.aluOp = ALU_SLLW;
                    10'b0000000_101: decCtrl.aluOp = ALU_SRLW;
                    10'b0100000_101: decCtrl.aluOp = ALU_SRAW;
                    default:         illegal = 1'b1;
                endcase
            end
            OP_IMM: begin
                decImm      = immI;
                decCtrl.src = SRC_REG_IMM;
                decCtrl.wb  = WB_EXE;
                case (funct3)
                    3'b000: decCtrl.aluOp = ALU_ADD;
                    3'b010: decCtrl.aluOp = ALU_SLT;
                    3'b011: decCtrl.aluOp = ALU_SLTU;
                    3'b100: decCtrl.aluOp = ALU_XOR;
                    3'b110: decCtrl.aluOp = ALU_OR;
                    3'b111: decCtrl.aluOp = ALU_AND;
                    3'b001: begin
                        if (funct6 == 6'b000000) begin
                            decCtrl.aluOp = ALU_SLL;
                        end else begin
                            illegal = 1'b1;
                        end
                    end
                    default: begin // 101, logical or arithmetic right shift
                        if (funct6 == 6'b000000) begin
                            decCtrl.aluOp = ALU_SRL;
                        end else if (funct6 == 6'b010000) begin
                            decCtrl.aluOp = ALU_SRA;
                        end else begin
                            illegal = 1'b1;
                        end
                    end
                endcase
            end
            OP_IMM32: begin
                // funct7 includes shamt bit 5, so a 6-bit word shift falls to illegal
                decImm      = immI;
                decCtrl.src = SRC_REG_IMM;
                decCtrl.wb  = WB_EXE;
                case ({funct7, funct3})
                    10'b0000000_001: decCtrl.aluOp = ALU_SLLW;
                    10'b0000000_101: decCtrl.aluOp = ALU_SRLW;
                    10'b0100000_101: decCtrl.aluOp = ALU_SRAW;
                    default: begin
                        if (funct3 == 3'b000) begin
                            decCtrl.aluOp = ALU_ADDW;
                        end else begin
                            illegal = 1'b1;
                        end
                    end
                endcase
            end
            OP_LOAD: begin
                decImm        = immI;
                decCtrl.aluOp = ALU_ADD; // address is rs1 + offset
                decCtrl.src   = SRC_REG_IMM;
                decCtrl.wb    = WB_MEM;
                case (funct3)
                    3'b000:  decCtrl.memOp = MEM_LB;
                    3'b001:  decCtrl.memOp = MEM_LH;
                    3'b010:  decCtrl.memOp = MEM_LW;
                    3'b011:  decCtrl.memOp = MEM_LD;
                    3'b100:  decCtrl.memOp = MEM_LBU;
                    3'b101:  decCtrl.memOp = MEM_LHU;
                    3'b110:  decCtrl.memOp = MEM_LWU;
                    default: illegal = 1'b1;
                endcase
            end
            OP_STORE: begin
                decImm        = immS;
                decCtrl.aluOp = ALU_ADD;
                decCtrl.src   = SRC_REG_IMM;
                case (funct3)
                    3'b000:  decCtrl.memOp = MEM_SB;
                    3'b001:  decCtrl.memOp = MEM_SH;
                    3'b010:  decCtrl.memOp = MEM_SW;
                    3'b011:  decCtrl.memOp = MEM_SD;
                    default: illegal = 1'b1;
                endcase
            end
            OP_BRANCH: begin
                // a branch writes no register, so rd carries funct3 to the branch unit
                decImm     = immB;
                decType    = CT_BRANCH;
                decCtrl.rd = {2'b00, funct3};
                if (funct3 == 3'b010 || funct3 == 3'b011) begin
                    illegal = 1'b1;
                end
            end
            OP_JAL: begin
                decImm     = immJ;
                decType    = CT_JAL;
                decCtrl.wb = WB_SNPC;
            end
            OP_JALR: begin
                decImm = immI;
                if (funct3 == 3'b000) begin
                    decType    = CT_JALR;
                    decCtrl.wb = WB_SNPC;
                end else begin
                    illegal = 1'b1;
                end
            end
            OP_LUI: begin
                decImm     = immU;
                decCtrl.wb = WB_IMM;
            end
            OP_AUIPC: begin
                decImm        = immU;
                decCtrl.aluOp = ALU_ADD;
                decCtrl.src   = SRC_PC_IMM;
                decCtrl.wb    = WB_EXE;
            end
            default: illegal = 1'b1; // system, fence, CSR and unknown opcodes
        endcase

        decCtrl.imm = decImm;

        if (illegal) begin
            decCtrl.aluOp = ALU_NOP;
            decCtrl.src   = SRC_NOP;
            decCtrl.memOp = MEM_NOP;
            decCtrl.wb    = WB_NOP;
            decCtrl.trap  = TRAP_ILLEGAL;
            decType       = CT_NOP;
        end

        // a fetch trap wins over whatever the word decoded to
        if (inBundle.trap != TRAP_NONE) begin
            decCtrl      = '0;
            decCtrl.pc   = inBundle.pc;
            decCtrl.trap = inBundle.trap;
            decImm       = '0;
            decType      = CT_NOP;
        end
    end

endmodule

`default_nettype wire

// File: source/issueRegister.sv
`default_nettype none

module issueRegister
    import decode_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      inValid,
    input  logic      flush,
    input  logic      conflict,
    input  logic      ifOk,
    input  logic      exeReady,
    input  ctrlType_e decType,
    input  exeCtrl_t  decCtrl,
    output logic      inReady,
    output logic      outValid,
    output exeCtrl_t  outCtrl
);

    logic slotFree;
    logic fetchTrap;
    logic load;

    assign slotFree  = !outValid || exeReady;
    assign fetchTrap = decCtrl.trap != TRAP_NONE && decCtrl.trap != TRAP_ILLEGAL;

    always_comb begin
        if (flush) begin
            inReady = 1'b1; // the word is dropped by the flush
        end else if (!inValid) begin
            inReady = 1'b1;
        end else if (fetchTrap) begin
            inReady = slotFree;
        end else if (conflict) begin
            inReady = 1'b0;
        end else if (decType != CT_NOP) begin
            inReady = slotFree && ifOk; // wait until fetch has taken the redirect
        end else begin
            inReady = slotFree;
        end
    end

    assign load = inValid && inReady && !flush;

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
        end else if (flush) begin
            outValid <= 1'b0;
        end else if (load) begin
            outValid <= 1'b1;
        end else if (exeReady) begin
            outValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            outCtrl <= decCtrl;
        end
    end

endmodule

`default_nettype wire

// File: tests/decodeStage_properties.sv
`default_nettype none

module decodeStage_properties
    import decode_pkg::*;
(
    input logic         clk,
    input logic         rst,
    input logic         inValid,
    input fetchBundle_t inBundle,
    input logic         conflict,
    input logic         flush,
    input logic         ifOk,
    input logic         exeReady,
    input logic         inReady,
    input logic         redirect,
    input logic         outValid,
    input exeCtrl_t     outCtrl
);
    timeunit 1ns;
    timeprecision 1ps;

    int failCount = 0;

    takeRaisesValid: assert property (@(posedge clk) disable iff (rst)
        inValid && inReady && !flush |=> outValid)
        else begin
            failCount++;
            $error("outValid did not rise after a take");
        end

    holdUnderStall: assert property (@(posedge clk) disable iff (rst)
        outValid && !exeReady |=> $stable(outCtrl))
        else begin
            failCount++;
            $error("outCtrl changed under back-pressure");
        end

    // a hazard blocks every untrapped instruction unless commit flushes it
    conflictBlocks: assert property (@(posedge clk) disable iff (rst)
        inValid && conflict && !flush && inBundle.trap == TRAP_NONE |-> !inReady)
        else begin
            failCount++;
            $error("instruction accepted during a conflict");
        end

    flushClears: assert property (@(posedge clk) disable iff (rst)
        flush |=> !outValid)
        else begin
            failCount++;
            $error("outValid high after a flush");
        end

    redirectWaits: assert property (@(posedge clk) disable iff (rst)
        redirect && !ifOk |-> !(inValid && inReady))
        else begin
            failCount++;
            $error("control transfer taken before fetch accepted it");
        end

    resetIdle: assert property (@(posedge clk)
        rst |=> !outValid && !redirect)
        else begin
            failCount++;
            $error("outValid or redirect high after reset");
        end

endmodule

bind decodeStage decodeStage_properties props (.*);

`default_nettype wire

// File: tests/decodeStage_tb.sv
`default_nettype none

`include "decode_defs.svh"

module decodeStage_tb
    import decode_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic [31:0] inst;
        aluOp_e      alu;
        srcSel_e     src;
        memOp_e      mem;
        wbSel_e      wb;
        trap_e       trap;
    } entry_t;

    logic             clk = 1'b0;
    logic             rst;
    logic             inValid;
    fetchBundle_t     inBundle;
    logic             conflict;
    logic             flush;
    logic             ifOk;
    logic             exeReady;
    logic             inReady;
    logic             redirect;
    logic [`XLEN-1:0] nextPc;
    logic             outValid;
    exeCtrl_t         outCtrl;

    logic [31:0] seed = 32'h1652_a8ce;
    exeCtrl_t    expQ[$];
    int          errors = 0;
    int          takes = 0;

    decodeStage UUT (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] nextRand();
        seed ^= seed << 13;
        seed ^= seed >> 17;
        seed ^= seed << 5;
        return seed;
    endfunction

    // legal encodings of the kept operations plus illegal words
    function automatic entry_t pick(input int i, input logic [31:0] r);
        case (i)
            0:  return '{32'h003100b3, ALU_ADD, SRC_REG_REG, MEM_NOP, WB_EXE, TRAP_NONE};
            1:  return '{32'h403100b3, ALU_SUB, SRC_REG_REG, MEM_NOP, WB_EXE, TRAP_NONE};
            2:  return '{32'h403150b3, ALU_SRA, SRC_REG_REG, MEM_NOP, WB_EXE, TRAP_NONE};
            3:  return '{32'h403100bb, ALU_SUBW, SRC_REG_REG, MEM_NOP, WB_EXE, TRAP_NONE};
            4:  return '{32'h403150bb, ALU_SRAW, SRC_REG_REG, MEM_NOP, WB_EXE, TRAP_NONE};
            5:  return '{32'hffb10093, ALU_ADD, SRC_REG_IMM, MEM_NOP, WB_EXE, TRAP_NONE};
            6:  return '{32'h42115093, ALU_SRA, SRC_REG_IMM, MEM_NOP, WB_EXE, TRAP_NONE};
            7:  return '{32'h0071009b, ALU_ADDW, SRC_REG_IMM, MEM_NOP, WB_EXE, TRAP_NONE};
            8:  return '{32'h4031509b, ALU_SRAW, SRC_REG_IMM, MEM_NOP, WB_EXE, TRAP_NONE};
            9:  return '{32'h0211109b, ALU_NOP, SRC_NOP, MEM_NOP, WB_NOP, TRAP_ILLEGAL};
            10: return '{32'h00813083, ALU_ADD, SRC_REG_IMM, MEM_LD, WB_MEM, TRAP_NONE};
            11: return '{32'h00814083, ALU_ADD, SRC_REG_IMM, MEM_LBU, WB_MEM, TRAP_NONE};
            12: return '{32'hfe312e23, ALU_ADD, SRC_REG_IMM, MEM_SW, WB_NOP, TRAP_NONE};
            13: return '{32'h123450b7, ALU_NOP, SRC_NOP, MEM_NOP, WB_IMM, TRAP_NONE};
            14: return '{32'h80000097, ALU_ADD, SRC_PC_IMM, MEM_NOP, WB_EXE, TRAP_NONE};
            15: return '{32'h00310863, ALU_NOP, SRC_NOP, MEM_NOP, WB_NOP, TRAP_NONE};
            16: return '{32'hfe316ce3, ALU_NOP, SRC_NOP, MEM_NOP, WB_NOP, TRAP_NONE};
            17: return '{32'h00315863, ALU_NOP, SRC_NOP, MEM_NOP, WB_NOP, TRAP_NONE};
            18: return '{32'h001000ef, ALU_NOP, SRC_NOP, MEM_NOP, WB_SNPC, TRAP_NONE};
            19: return '{32'h004100e7, ALU_NOP, SRC_NOP, MEM_NOP, WB_SNPC, TRAP_NONE};
            20: return '{32'h023100b3, ALU_NOP, SRC_NOP, MEM_NOP, WB_NOP, TRAP_ILLEGAL};
            21: return '{32'h003110b3, ALU_SLL, SRC_REG_REG, MEM_NOP, WB_EXE, TRAP_NONE};
            22: return '{32'h003120b3, ALU_SLT, SRC_REG_REG, MEM_NOP, WB_EXE, TRAP_NONE};
            23: return '{32'h003130b3, ALU_SLTU, SRC_REG_REG, MEM_NOP, WB_EXE, TRAP_NONE};
            24: return '{32'h003140b3, ALU_XOR, SRC_REG_REG, MEM_NOP, WB_EXE, TRAP_NONE};
            25: return '{32'h003150b3, ALU_SRL, SRC_REG_REG, MEM_NOP, WB_EXE, TRAP_NONE};
            26: return '{32'h003160b3, ALU_OR, SRC_REG_REG, MEM_NOP, WB_EXE, TRAP_NONE};
            27: return '{32'h003170b3, ALU_AND, SRC_REG_REG, MEM_NOP, WB_EXE, TRAP_NONE};
            28: return '{32'h003100bb, ALU_ADDW, SRC_REG_REG, MEM_NOP, WB_EXE, TRAP_NONE};
            29: return '{32'h003110bb, ALU_SLLW, SRC_REG_REG, MEM_NOP, WB_EXE, TRAP_NONE};
            30: return '{32'h003150bb, ALU_SRLW, SRC_REG_REG, MEM_NOP, WB_EXE, TRAP_NONE};
            31: return '{32'hffb12093, ALU_SLT, SRC_REG_IMM, MEM_NOP, WB_EXE, TRAP_NONE};
            32: return '{32'h00513093, ALU_SLTU, SRC_REG_IMM, MEM_NOP, WB_EXE, TRAP_NONE};
            33: return '{32'h0ff14093, ALU_XOR, SRC_REG_IMM, MEM_NOP, WB_EXE, TRAP_NONE};
            34: return '{32'h80016093, ALU_OR, SRC_REG_IMM, MEM_NOP, WB_EXE, TRAP_NONE};
            35: return '{32'h7ff17093, ALU_AND, SRC_REG_IMM, MEM_NOP, WB_EXE, TRAP_NONE};
            36: return '{32'h03f11093, ALU_SLL, SRC_REG_IMM, MEM_NOP, WB_EXE, TRAP_NONE};
            37: return '{32'h00115093, ALU_SRL, SRC_REG_IMM, MEM_NOP, WB_EXE, TRAP_NONE};
            38: return '{32'h01f1109b, ALU_SLLW, SRC_REG_IMM, MEM_NOP, WB_EXE, TRAP_NONE};
            39: return '{32'h0031509b, ALU_SRLW, SRC_REG_IMM, MEM_NOP, WB_EXE, TRAP_NONE};
            40: return '{32'h00810083, ALU_ADD, SRC_REG_IMM, MEM_LB, WB_MEM, TRAP_NONE};
            41: return '{32'h00811083, ALU_ADD, SRC_REG_IMM, MEM_LH, WB_MEM, TRAP_NONE};
            42: return '{32'h00812083, ALU_ADD, SRC_REG_IMM, MEM_LW, WB_MEM, TRAP_NONE};
            43: return '{32'h00815083, ALU_ADD, SRC_REG_IMM, MEM_LHU, WB_MEM, TRAP_NONE};
            44: return '{32'h00816083, ALU_ADD, SRC_REG_IMM, MEM_LWU, WB_MEM, TRAP_NONE};
            45: return '{32'hfe310e23, ALU_ADD, SRC_REG_IMM, MEM_SB, WB_NOP, TRAP_NONE};
            46: return '{32'hfe311e23, ALU_ADD, SRC_REG_IMM, MEM_SH, WB_NOP, TRAP_NONE};
            47: return '{32'hfe313e23, ALU_ADD, SRC_REG_IMM, MEM_SD, WB_NOP, TRAP_NONE};
            48: return '{32'h00311863, ALU_NOP, SRC_NOP, MEM_NOP, WB_NOP, TRAP_NONE};
            49: return '{32'h00314863, ALU_NOP, SRC_NOP, MEM_NOP, WB_NOP, TRAP_NONE};
            50: return '{32'h00317863, ALU_NOP, SRC_NOP, MEM_NOP, WB_NOP, TRAP_NONE};
            51: return '{32'h40111093, ALU_NOP, SRC_NOP, MEM_NOP, WB_NOP, TRAP_ILLEGAL};
            52: return '{32'h00817083, ALU_NOP, SRC_NOP, MEM_NOP, WB_NOP, TRAP_ILLEGAL};
            53: return '{32'h00312863, ALU_NOP, SRC_NOP, MEM_NOP, WB_NOP, TRAP_ILLEGAL};
            54: return '{32'h004110e7, ALU_NOP, SRC_NOP, MEM_NOP, WB_NOP, TRAP_ILLEGAL};
            default: return '{{r[31:7], 7'b1110011}, ALU_NOP, SRC_NOP, MEM_NOP, WB_NOP,
                              TRAP_ILLEGAL}; // system opcode with random fields
        endcase
    endfunction

    function automatic logic [63:0] immOf(input logic [31:0] w);
        case (w[6:0])
            7'b0000011, 7'b0010011, 7'b0011011, 7'b1100111:
                return {{52{w[31]}}, w[31:20]};
            7'b0100011: return {{52{w[31]}}, w[31:25], w[11:7]};
            7'b1100011: return {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            7'b0110111, 7'b0010111: return {{32{w[31]}}, w[31:12], 12'h0};
            7'b1101111: return {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            default: return '0;
        endcase
    endfunction

    function automatic logic [63:0] targetOf(input logic [31:0] w, input logic [63:0] pc,
                                             input logic [63:0] a, input logic [63:0] b);
        logic taken;
        case (w[14:12])
            3'b000:  taken = a == b;
            3'b001:  taken = a != b;
            3'b100:  taken = $signed(a) < $signed(b);
            3'b101:  taken = $signed(a) >= $signed(b);
            3'b110:  taken = a < b;
            default: taken = a >= b;
        endcase
        if (w[6:0] == 7'b1101111) return pc + immOf(w);
        if (w[6:0] == 7'b1100111) return (a + immOf(w)) & ~64'h1;
        return taken ? pc + immOf(w) : pc + `PC_STEP;
    endfunction

    task automatic checkOut(input exeCtrl_t exp);
        assert ({outCtrl.aluOp, outCtrl.src, outCtrl.memOp, outCtrl.wb, outCtrl.trap} ==
                {exp.aluOp, exp.src, exp.memOp, exp.wb, exp.trap})
        else begin
            errors++;
            $display("ERR outCtrl.{aluOp,src,memOp,wb,trap} got %h exp %h",
                     {outCtrl.aluOp, outCtrl.src, outCtrl.memOp, outCtrl.wb, outCtrl.trap},
                     {exp.aluOp, exp.src, exp.memOp, exp.wb, exp.trap});
        end
        assert (outCtrl.pc == exp.pc)
        else begin
            errors++;
            $display("ERR outCtrl.pc got %h exp %h", outCtrl.pc, exp.pc);
        end
        assert (exp.trap != TRAP_NONE || outCtrl.imm == exp.imm)
        else begin
            errors++;
            $display("ERR outCtrl.imm got %h exp %h", outCtrl.imm, exp.imm);
        end
        assert (exp.trap != TRAP_NONE || {outCtrl.rs1, outCtrl.rs2} == {exp.rs1, exp.rs2})
        else begin
            errors++;
            $display("ERR outCtrl.{rs1,rs2} got %h exp %h",
                     {outCtrl.rs1, outCtrl.rs2}, {exp.rs1, exp.rs2});
        end
        // rd only matters where a register is written back
        assert (exp.wb == WB_NOP || outCtrl.rd == exp.rd)
        else begin
            errors++;
            $display("ERR outCtrl.rd got %h exp %h", outCtrl.rd, exp.rd);
        end
    endtask

    // drive one cycle at the falling edge and predict what the next rising edge does
    task automatic stepCycle(input bit drain);
        logic [31:0] r;
        entry_t      e;
        exeCtrl_t    exp;
        logic        isCf;
        logic        expRedirect;
        @(negedge clk);
        r = nextRand();
        e = pick(int'(nextRand() % 32'd56), nextRand());
        inBundle.instruction = e.inst;
        inBundle.pc          = {32'h0, nextRand() & ~32'h3};
        inBundle.rs1Data     = {nextRand(), nextRand()};
        inBundle.rs2Data     = r[5] ? inBundle.rs1Data : {nextRand(), nextRand()};
        inBundle.trap        = r[9:6] == 0 ? (r[22] ? TRAP_FETCH_MISALIGN : TRAP_FETCH_FAULT)
                                           : TRAP_NONE;
        inValid  = !drain && (r[10] || r[11]);
        conflict = r[13:12] == 0;
        ifOk     = r[15:14] != 0;
        exeReady = drain || r[17:16] != 0;
        flush    = !drain && r[21:18] == 0;
        exp    = '0;
        exp.pc = inBundle.pc;
        if (inBundle.trap != TRAP_NONE) begin
            exp.trap = inBundle.trap; // fetch trap passes through alone
        end else begin
            exp.rd    = e.inst[11:7];
            exp.rs1   = e.inst[19:15];
            exp.rs2   = e.inst[24:20];
            exp.imm   = immOf(e.inst);
            exp.aluOp = e.alu;
            exp.src   = e.src;
            exp.memOp = e.mem;
            exp.wb    = e.wb;
            exp.trap  = e.trap;
        end
        isCf = e.inst[6:0] inside {7'b1100011, 7'b1101111, 7'b1100111} && e.trap == TRAP_NONE;
        expRedirect = inValid && !flush && inBundle.trap == TRAP_NONE && isCf;
        #1;
        assert (redirect == expRedirect)
        else begin
            errors++;
            $display("ERR redirect got %h exp %h", redirect, expRedirect);
        end
        if (redirect) begin
            assert (nextPc == targetOf(e.inst, inBundle.pc, inBundle.rs1Data, inBundle.rs2Data))
            else begin
                errors++;
                $display("ERR nextPc got %h exp %h", nextPc,
                         targetOf(e.inst, inBundle.pc, inBundle.rs1Data, inBundle.rs2Data));
            end
        end
        if (outValid && exeReady) begin
            if (expQ.size() == 0) begin
                errors++;
                $display("execute consumed an output that no instruction produced");
            end else begin
                checkOut(expQ.pop_front());
            end
        end
        if (flush) expQ.delete(); // the slot is emptied by the flush
        if (inValid && inReady && !flush) begin
            expQ.push_back(exp);
            takes++;
        end
    endtask

    initial begin
        int cycles;
        rst      = 1'b1;
        inValid  = 1'b0;
        inBundle = '0;
        conflict = 1'b0;
        flush    = 1'b0;
        ifOk     = 1'b1;
        exeReady = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        cycles = 0;
        while (takes < 400 && cycles < 20000) begin
            stepCycle(1'b0);
            cycles++;
        end
        if (takes < 400) begin
            errors++;
            $display("timed out waiting for the stage to take instructions");
        end
        cycles = 0;
        while (expQ.size() != 0 && cycles < 50) begin
            stepCycle(1'b1);
            cycles++;
        end
        if (expQ.size() != 0) begin
            errors++;
            $display("timed out waiting for the ID/EX slot to drain");
        end
        @(negedge clk);
        $display("errors: model %0d, properties %0d", errors, UUT.props.failCount);
        if (errors == 0 && UUT.props.failCount == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire
